//--- Makefile
# Verilator build and run of the sound core testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sound.f \
		--top-module sound_tb -Mdir obj_dir -o sound_tb
	./obj_dir/sound_tb | tee $(LOG)
	@if grep -q "Verification passed" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- common/reg_bus_if.sv
/*
 * byte register bus from the address decoder to one device
 * single-cycle read/write strobes, readdata combinational while read is high
 */
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if;
    logic [3:0] addr;
    logic       read;
    logic       write;
    logic [7:0] writedata;
    logic [7:0] readdata;

    modport host (output addr, read, write, writedata, input readdata);
    modport dev  (input addr, read, write, writedata, output readdata);
endinterface

`default_nettype wire

//--- common/sound_pkg.sv
/*
 * shared definitions for the sound card core
 * DSP opcodes and parser states, port offsets, OPL register indices,
 * management addresses and the reset defaults of the timing registers
 */
`default_nettype none

package sound_pkg;

    // ------------------------------
    // DSP
    typedef enum logic [7:0] {
        DIRECT_DAC  = 8'h10,    // one byte straight to the DAC
        DMA8_SINGLE = 8'h14,    // 8-bit single-cycle playback
        TIME_CONST  = 8'h40,
        SPEAKER_ON  = 8'hD1,
        SPEAKER_OFF = 8'hD3
    } dsp_cmd_e;

    typedef enum logic [2:0] {
        IDLE, DAC_DATA, TC_DATA, LEN_LO, LEN_HI, DMA_RUN
    } dsp_state_e;

    localparam logic [7:0] DSP_RESET_ACK   = 8'hAA;
    localparam logic [3:0] DSP_PORT_RESET  = 4'h6;
    localparam logic [3:0] DSP_PORT_READ   = 4'hA;
    localparam logic [3:0] DSP_PORT_WRITE  = 4'hC;
    localparam logic [3:0] DSP_PORT_STATUS = 4'hE;  // bit 7 = read data ready

    // ------------------------------
    // OPL register indices
    localparam logic [7:0] OPL_REG_TIMER1      = 8'h02;
    localparam logic [7:0] OPL_REG_TIMER2      = 8'h03;
    localparam logic [7:0] OPL_REG_TIMER_CTRL  = 8'h04;
    localparam logic [7:0] OPL_REG_LEVEL       = 8'h40;
    localparam logic [7:0] OPL_REG_FNUM_LO     = 8'hA0;
    localparam logic [7:0] OPL_REG_KEY_FNUM_HI = 8'hB0;

    // ------------------------------
    // management port, 0-255 is the cycles-per-byte table
    localparam logic [8:0]  MGMT_ADDR_80US      = 9'd256;
    localparam logic [8:0]  MGMT_ADDR_SAMPLE    = 9'd257;
    localparam logic [12:0] PERIOD_80US_RESET   = 13'd2400;
    localparam logic [9:0]  SAMPLE_CYCLES_RESET = 10'd520;

    localparam int SAMPLE_W = 16;   // output sample width

endpackage

`default_nettype wire

//--- dsp/sound_dsp.sv
/*
 * Sound Blaster style DSP
 * reset handshake on port 6, command bytes on port C, direct DAC,
 * speaker control and 8-bit single-cycle DMA playback paced by a
 * cycles-per-byte table loaded over the management port
 */
`timescale 1ns/1ps
`default_nettype none

module sound_dsp
    import sound_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    reg_bus_if.dev      bus,
    output logic        irq,

    output logic        dma_req,
    input  logic        dma_ack,
    input  logic        dma_terminal,
    input  logic [7:0]  dma_readdata,

    output logic        sample_do,
    output logic [7:0]  sample_value,       // unsigned
    output logic        sample_disabled,

    input  logic [8:0]  mgmt_address,
    input  logic        mgmt_write,
    input  logic [31:0] mgmt_writedata
);

    dsp_state_e  state;
    logic        reset_hold;                // port 6 bit 0 seen high
    logic        read_ready;
    logic [7:0]  read_data;
    logic        speaker_on;
    logic [7:0]  time_const;
    logic [15:0] block_len;                 // bytes minus one
    logic [15:0] byte_cnt;
    logic [15:0] period_cnt;
    logic [15:0] cycles_tab [0:255];

    logic        wr_reset;
    logic        wr_cmd;
    logic        rd_data;
    logic        rd_status;
    logic        soft_reset;
    logic        dma_take;
    logic        block_end;

    assign wr_reset   = bus.write && bus.addr == DSP_PORT_RESET;
    assign wr_cmd     = bus.write && bus.addr == DSP_PORT_WRITE;
    assign rd_data    = bus.read && bus.addr == DSP_PORT_READ;
    assign rd_status  = bus.read && bus.addr == DSP_PORT_STATUS;
    assign soft_reset = wr_reset && !bus.writedata[0] && reset_hold;   // 1 then 0
    assign dma_take   = state == DMA_RUN && dma_req && dma_ack;
    assign block_end  = dma_take && (dma_terminal || byte_cnt == block_len);

    assign sample_disabled = !speaker_on;

    always_comb begin
        bus.readdata = 8'hFF;
        if (bus.read) begin
            case (bus.addr)
                DSP_PORT_READ:   bus.readdata = read_data;
                DSP_PORT_WRITE:  bus.readdata = 8'h7F;     // never busy
                DSP_PORT_STATUS: bus.readdata = {read_ready, 7'h7F};
                default:         bus.readdata = 8'hFF;
            endcase
        end
    end

    // cycles per byte, indexed by time constant
    always_ff @(posedge clk) begin
        if (mgmt_write && !mgmt_address[8])
            cycles_tab[mgmt_address[7:0]] <= mgmt_writedata[15:0];
    end

    // ------------------------------
    // reset handshake and read buffer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reset_hold <= 1'b0;
            read_ready <= 1'b0;
            read_data  <= 8'h00;
        end else begin
            if (wr_reset)
                reset_hold <= bus.writedata[0];
            if (soft_reset) begin
                read_data  <= DSP_RESET_ACK;
                read_ready <= 1'b1;
            end else if (rd_data) begin
                read_ready <= 1'b0;             // byte consumed
            end
        end
    end

    // ------------------------------
    // command parser and DMA engine
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            speaker_on   <= 1'b0;
            time_const   <= 8'h00;
            block_len    <= 16'h0000;
            byte_cnt     <= 16'h0000;
            period_cnt   <= 16'h0000;
            dma_req      <= 1'b0;
            irq          <= 1'b0;
            sample_do    <= 1'b0;
            sample_value <= 8'h80;
        end else begin
            sample_do <= 1'b0;
            if (rd_status)
                irq <= 1'b0;                    // ack by status read
            if (soft_reset) begin
                state   <= IDLE;
                dma_req <= 1'b0;
                irq     <= 1'b0;
            end else begin
                case (state)
                    IDLE: if (wr_cmd) begin
                        case (bus.writedata)
                            DIRECT_DAC:  state <= DAC_DATA;
                            TIME_CONST:  state <= TC_DATA;
                            DMA8_SINGLE: state <= LEN_LO;
                            SPEAKER_ON:  speaker_on <= 1'b1;
                            SPEAKER_OFF: speaker_on <= 1'b0;
                            default:     state <= IDLE;     // unknown, dropped
                        endcase
                    end
                    DAC_DATA: if (wr_cmd) begin
                        sample_do    <= 1'b1;
                        sample_value <= bus.writedata;
                        state        <= IDLE;
                    end
                    TC_DATA: if (wr_cmd) begin
                        time_const <= bus.writedata;
                        state      <= IDLE;
                    end
                    LEN_LO: if (wr_cmd) begin
                        block_len[7:0] <= bus.writedata;
                        state          <= LEN_HI;
                    end
                    LEN_HI: if (wr_cmd) begin
                        block_len[15:8] <= bus.writedata;
                        byte_cnt        <= 16'h0000;
                        dma_req         <= 1'b1;        // first byte at once
                        state           <= DMA_RUN;
                    end
                    DMA_RUN: begin
                        if (dma_take) begin
                            sample_do    <= 1'b1;
                            sample_value <= dma_readdata;
                            dma_req      <= 1'b0;
                            if (block_end) begin
                                irq   <= 1'b1;
                                state <= IDLE;
                            end else begin
                                byte_cnt   <= byte_cnt + 16'd1;
                                period_cnt <= cycles_tab[time_const];
                            end
                        end else if (!dma_req) begin
                            // pacing, frozen while a request is open
                            if (period_cnt > 16'd1)
                                period_cnt <= period_cnt - 16'd1;
                            else
                                dma_req <= 1'b1;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // the DMA controller answers only open requests
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        dma_ack |-> dma_req)
        else $error("dma_ack without dma_req");

    // playback ends only by count, terminal or soft reset
    a_dma_run_hold: assert property (@(posedge clk) disable iff (!rst_n)
        state == DMA_RUN && !block_end && !soft_reset |=> state == DMA_RUN)
        else $error("left DMA_RUN without block end");

endmodule

`default_nettype wire

//--- opl/opl_timers.sv
/*
 * reduced OPL register file with the two timers
 * offset 0 write latches the index, read returns status; offset 1 writes data
 * timer 1 ticks every period_80us cycles, timer 2 every fourth of those
 */
`timescale 1ns/1ps
`default_nettype none

module opl_timers
    import sound_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    reg_bus_if.dev      bus,
    input  logic [12:0] period_80us,
    output logic        timer_irq,
    output logic [9:0]  fnum,
    output logic        key_on,
    output logic [5:0]  level
);

    logic [7:0]  index;
    logic [7:0]  load  [2];
    logic [7:0]  count [2];
    logic        flag  [2];
    logic [1:0]  start;                 // ctrl bits 1:0
    logic [1:0]  mask;                  // ctrl bits 6 (t1) and 5 (t2)
    logic [1:0]  tick;
    logic [12:0] pre_cnt;
    logic [1:0]  div4;
    logic        tick_80us;
    logic        wr_data;
    logic        irq_reset;
    logic [7:0]  status;

    assign wr_data   = bus.write && bus.addr[0];
    assign irq_reset = wr_data && index == OPL_REG_TIMER_CTRL && bus.writedata[7];

    assign status    = {flag[0] || flag[1], flag[0], flag[1], 5'd0};
    assign timer_irq = (flag[0] && !mask[0]) || (flag[1] && !mask[1]);

    always_comb begin
        bus.readdata = 8'hFF;
        if (bus.read && !bus.addr[0])
            bus.readdata = status;
    end

    // ------------------------------
    // index and data registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index   <= 8'h00;
            load[0] <= 8'h00;
            load[1] <= 8'h00;
            start   <= 2'b00;
            mask    <= 2'b00;
            fnum    <= 10'd0;
            key_on  <= 1'b0;
            level   <= 6'd0;
        end else begin
            if (bus.write && !bus.addr[0])
                index <= bus.writedata;
            if (wr_data) begin
                case (index)
                    OPL_REG_TIMER1: load[0] <= bus.writedata;
                    OPL_REG_TIMER2: load[1] <= bus.writedata;
                    OPL_REG_TIMER_CTRL: if (!bus.writedata[7]) begin
                        start <= bus.writedata[1:0];
                        mask  <= {bus.writedata[5], bus.writedata[6]};
                    end
                    OPL_REG_LEVEL:   level     <= bus.writedata[5:0];
                    OPL_REG_FNUM_LO: fnum[7:0] <= bus.writedata;
                    OPL_REG_KEY_FNUM_HI: begin
                        key_on    <= bus.writedata[5];
                        fnum[9:8] <= bus.writedata[1:0];
                    end
                    default: index <= index;    // unused register
                endcase
            end
        end
    end

    // ------------------------------
    // 80 us prescaler, /4 for timer 2
    assign tick_80us = {1'b0, pre_cnt} + 14'd1 >= {1'b0, period_80us};
    assign tick      = {tick_80us && div4 == 2'd3, tick_80us};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_cnt <= 13'd0;
            div4    <= 2'd0;
        end else begin
            pre_cnt <= tick_80us ? 13'd0 : pre_cnt + 13'd1;
            if (tick_80us)
                div4 <= div4 + 2'd1;
        end
    end

    // up-counters, overflow after 256 - load ticks
    for (genvar i = 0; i < 2; i++) begin : g_timer
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                count[i] <= 8'h00;
                flag[i]  <= 1'b0;
            end else begin
                if (!start[i]) begin
                    count[i] <= load[i];        // stopped, hold preset
                end else if (tick[i]) begin
                    if (count[i] == 8'hFF) begin
                        count[i] <= load[i];
                        flag[i]  <= 1'b1;
                    end else begin
                        count[i] <= count[i] + 8'd1;
                    end
                end
                if (irq_reset)
                    flag[i] <= 1'b0;
            end
        end
    end

    // flags are sticky until the interrupt reset
    a_status_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        status[7] && !irq_reset |=> status[7])
        else $error("status bit 7 dropped without interrupt reset");

endmodule

`default_nettype wire

//--- opl/opl_tone.sv
/*
 * single keyed square-wave channel standing in for FM synthesis
 * phase flips every fnum sample ticks, amplitude set by the level register
 */
`timescale 1ns/1ps
`default_nettype none

module opl_tone
    import sound_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sample_tick,
    input  logic [9:0]          fnum,
    input  logic                key_on,
    input  logic [5:0]          level,          // attenuation, 0 = loudest
    output logic [SAMPLE_W-1:0] tone_sample     // signed
);

    logic [9:0]          tick_cnt;
    logic                phase;
    logic [SAMPLE_W-1:0] amp;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= 10'd0;
            phase    <= 1'b0;
        end else if (!key_on) begin
            tick_cnt <= 10'd0;                  // restart on next key-on
            phase    <= 1'b0;
        end else if (sample_tick && fnum != 10'd0) begin
            if (tick_cnt + 10'd1 >= fnum) begin
                tick_cnt <= 10'd0;
                phase    <= ~phase;
            end else begin
                tick_cnt <= tick_cnt + 10'd1;
            end
        end
    end

    // (63 - level) * 256
    assign amp = SAMPLE_W'({6'd63 - level, 8'h00});

    assign tone_sample = !key_on ? '0 : (phase ? -amp : amp);

endmodule

`default_nettype wire

//--- sim/sound_tb.sv
/*
 * testbench for the sound card core
 * drives the io, fm, mgmt and DMA ports of the top level, checks the DSP
 * handshake, direct DAC, DMA playback, OPL timers and the tone channel
 */
`timescale 1ns/1ps
`default_nettype none

module sound_tb
    import sound_pkg::*;
();

    logic                clk;
    logic                rst_n;
    logic                irq;
    logic [3:0]          io_address;
    logic                io_read;
    logic                io_write;
    logic [7:0]          io_writedata;
    logic [7:0]          io_readdata;
    logic [1:0]          fm_address;
    logic                fm_read;
    logic                fm_write;
    logic [7:0]          fm_writedata;
    logic [7:0]          fm_readdata;
    logic                dma_req;
    logic                dma_ack;
    logic                dma_terminal;
    logic [7:0]          dma_readdata;
    logic [SAMPLE_W-1:0] sample_l;
    logic [SAMPLE_W-1:0] sample_r;
    logic [8:0]          mgmt_address;
    logic                mgmt_write;
    logic [31:0]         mgmt_writedata;

    int         errors;
    int         checks;
    int         test_base;
    int         dma_idx;
    logic [7:0] dma_bytes [8];          // bytes served by the responder
    int         ack_delay [8];          // cycles before each ack

    sound DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;         // 100 ns period
    end

    // ------------------------------
    // reference model
    function automatic logic signed [15:0] dsp_to_sample(input logic [7:0] b);
        int v;
        v = (int'(b) - 128) * 256 + int'(b);    // offset binary, byte repeated low
        return 16'(v);
    endfunction

    function automatic logic signed [15:0] mix(input logic signed [15:0] a,
                                               input logic signed [15:0] b);
        int s;
        s = (int'(a) >>> 1) + (int'(b) >>> 1);  // half scale each
        return 16'(s);
    endfunction

    function automatic logic [7:0] timer_flags(input logic t1, input logic t2);
        logic [7:0] s;
        s = (t1 ? 8'h40 : 8'h00) | (t2 ? 8'h20 : 8'h00);   // bit 6 timer 1, bit 5 timer 2
        return s != 8'h00 ? s | 8'h80 : s;                  // bit 7 any flag
    endfunction

    // ------------------------------
    // compare and report
    task automatic check_byte(input string what, input logic [7:0] got,
                              input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0d ns: %s, got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_sample(input string what, input logic [SAMPLE_W-1:0] got,
                                input logic signed [SAMPLE_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0d ns: %s, got %0d expected %0d", $time, what,
                     $signed(got), exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0d ns: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic timed_out(input string what);
        errors++;
        $display("timeout at %0d ns, no %s", $time, what);
    endtask

    task automatic test_done(input string name);
        if (errors == test_base)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    // ------------------------------
    // bus access, inputs change 1 ns after the rising edge
    task automatic at_drive_point();
        @(posedge clk);
        #1;
    endtask

    task automatic io_wr(input logic [3:0] addr, input logic [7:0] data);
        at_drive_point();
        io_address   = addr;
        io_writedata = data;
        io_write     = 1'b1;
        at_drive_point();
        io_write     = 1'b0;
    endtask

    task automatic io_rd(input logic [3:0] addr, output logic [7:0] data);
        at_drive_point();
        io_address = addr;
        io_read    = 1'b1;
        @(negedge clk);
        data = io_readdata;             // side effect lands on the next edge
        at_drive_point();
        io_read    = 1'b0;
    endtask

    task automatic fm_wr(input logic [1:0] addr, input logic [7:0] data);
        at_drive_point();
        fm_address   = addr;
        fm_writedata = data;
        fm_write     = 1'b1;
        at_drive_point();
        fm_write     = 1'b0;
    endtask

    task automatic fm_rd(input logic [1:0] addr, output logic [7:0] data);
        at_drive_point();
        fm_address = addr;
        fm_read    = 1'b1;
        @(negedge clk);
        data = fm_readdata;
        at_drive_point();
        fm_read    = 1'b0;
    endtask

    task automatic opl_set(input logic [7:0] index, input logic [7:0] data);
        fm_wr(2'd0, index);
        fm_wr(2'd1, data);
    endtask

    task automatic dsp_send(input logic [7:0] data);
        io_wr(DSP_PORT_WRITE, data);
    endtask

    task automatic mgmt_load(input logic [8:0] addr, input logic [31:0] data);
        at_drive_point();
        mgmt_address   = addr;
        mgmt_writedata = data;
        mgmt_write     = 1'b1;
        at_drive_point();
        mgmt_write     = 1'b0;
    endtask

    // polls at the falling edge until an ack is open
    task automatic wait_ack(output logic seen);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!dma_ack && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        seen = dma_ack;
    endtask

    // ------------------------------
    // DMA responder, random ack delay per byte
    initial begin : dma_responder
        int d;
        dma_ack      = 1'b0;
        dma_terminal = 1'b0;            // DSP ends the block on its count
        dma_readdata = 8'h00;
        dma_idx      = 0;
        forever begin
            at_drive_point();
            if (dma_req) begin
                d = dma_idx < 8 ? ack_delay[dma_idx] : 0;
                repeat (d) at_drive_point();
                dma_readdata = dma_idx < 8 ? dma_bytes[dma_idx] : 8'h00;
                dma_ack      = 1'b1;
                at_drive_point();       // DSP takes the byte on this edge
                dma_ack      = 1'b0;
                dma_idx++;
            end
        end
    end

    // ------------------------------
    // test sequence
    initial begin
        logic [7:0]         rd;
        logic               seen;
        logic               seen_pos;
        logic               seen_neg;
        logic signed [15:0] tone_hi;
        logic [7:0]         dac_bytes [3];
        int                 waited;
        int                 k;

        errors = 0;
        checks = 0;
        test_base = 0;
        rst_n = 1'b0;
        io_address = 4'h0;
        io_read = 1'b0;
        io_write = 1'b0;
        io_writedata = 8'h00;
        fm_address = 2'd0;
        fm_read = 1'b0;
        fm_write = 1'b0;
        fm_writedata = 8'h00;
        mgmt_address = 9'd0;
        mgmt_write = 1'b0;
        mgmt_writedata = 32'd0;

        void'($urandom(32'hbe80c463));
        for (k = 0; k < 8; k++) begin
            dma_bytes[k] = 8'($urandom);
            ack_delay[k] = int'($urandom % 4);
        end
        dac_bytes[0] = 8'h80;           // midscale
        dac_bytes[1] = 8'h00;
        dac_bytes[2] = 8'($urandom);

        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;

        // small timing values keep the run short
        mgmt_load(MGMT_ADDR_80US, 32'd20);
        mgmt_load(MGMT_ADDR_SAMPLE, 32'd8);
        mgmt_load(9'd10, 32'd12);

        // ---- 1: reset handshake
        check_bit("irq after reset", irq, 1'b0);
        check_bit("dma_req after reset", dma_req, 1'b0);
        io_wr(DSP_PORT_RESET, 8'h01);
        io_wr(DSP_PORT_RESET, 8'h00);
        rd = 8'h00;
        waited = 0;
        while (!rd[7] && waited < 2) begin     // two reads span 4 cycles
            io_rd(DSP_PORT_STATUS, rd);
            waited++;
        end
        if (!rd[7])
            timed_out("read-ready flag after DSP reset");
        io_rd(DSP_PORT_READ, rd);
        check_byte("reset ack on port A", rd, DSP_RESET_ACK);
        test_done("1 dsp reset handshake");

        // ---- 2: direct DAC, speaker on then off
        dsp_send(SPEAKER_ON);
        for (k = 0; k < 3; k++) begin
            dsp_send(DIRECT_DAC);
            dsp_send(dac_bytes[k]);
            @(posedge clk);             // strobe, then top register
            @(negedge clk);
            check_sample("direct dac left", sample_l, mix(dsp_to_sample(dac_bytes[k]), 16'sd0));
            check_sample("direct dac right", sample_r, mix(dsp_to_sample(dac_bytes[k]), 16'sd0));
        end
        dsp_send(SPEAKER_OFF);
        @(posedge clk);
        @(negedge clk);
        check_sample("speaker off left", sample_l, 16'sd0);
        check_sample("speaker off right", sample_r, 16'sd0);
        test_done("2 direct dac and speaker");

        // ---- 3: single-cycle DMA, 8 bytes
        dsp_send(SPEAKER_ON);
        dsp_send(TIME_CONST);
        dsp_send(8'd10);
        dsp_send(DMA8_SINGLE);
        dsp_send(8'd7);                 // length minus one, low
        dsp_send(8'd0);
        for (k = 0; k < 8; k++) begin
            wait_ack(seen);
            if (!seen) begin
                timed_out("DMA ack");
                break;
            end
            check_bit("irq before block end", irq, 1'b0);
            @(posedge clk);             // byte taken
            @(posedge clk);             // sample register loaded
            @(negedge clk);
            check_sample("dma sample", sample_l, mix(dsp_to_sample(dma_bytes[k]), 16'sd0));
            check_bit("irq after byte", irq, k == 7);
        end
        io_rd(DSP_PORT_STATUS, rd);
        @(negedge clk);
        check_bit("irq after status read", irq, 1'b0);
        test_done("3 dma playback");

        // ---- 4: OPL timers
        opl_set(OPL_REG_TIMER1, 8'hFE);
        opl_set(OPL_REG_TIMER_CTRL, 8'h01);
        rd = 8'h00;
        waited = 0;
        while (rd == 8'h00 && waited < 60) begin
            fm_rd(2'd0, rd);
            waited++;
        end
        if (rd == 8'h00)
            timed_out("timer 1 overflow");
        check_byte("status after timer 1", rd, timer_flags(1'b1, 1'b0));
        @(negedge clk);
        check_bit("irq on timer 1", irq, 1'b1);
        opl_set(OPL_REG_TIMER_CTRL, 8'h80);
        fm_rd(2'd0, rd);
        check_byte("status after irq reset", rd, timer_flags(1'b0, 1'b0));

        opl_set(OPL_REG_TIMER_CTRL, 8'h00);     // stop timer 1
        opl_set(OPL_REG_TIMER_CTRL, 8'h80);
        opl_set(OPL_REG_TIMER2, 8'hFF);
        opl_set(OPL_REG_TIMER_CTRL, 8'h02);
        rd = 8'h00;
        waited = 0;
        while (rd == 8'h00 && waited < 150) begin
            fm_rd(2'd0, rd);
            waited++;
        end
        if (rd == 8'h00)
            timed_out("timer 2 overflow");
        check_byte("status after timer 2", rd, timer_flags(1'b0, 1'b1));
        opl_set(OPL_REG_TIMER_CTRL, 8'h00);
        opl_set(OPL_REG_TIMER_CTRL, 8'h80);
        @(negedge clk);
        check_bit("irq after timers cleared", irq, 1'b0);
        test_done("4 opl timers");

        // ---- 5: tone channel, DSP silent
        dsp_send(SPEAKER_OFF);
        opl_set(OPL_REG_LEVEL, 8'h00);
        opl_set(OPL_REG_FNUM_LO, 8'h03);
        opl_set(OPL_REG_KEY_FNUM_HI, 8'h20);    // key on, fnum high 0
        tone_hi = mix(16'sd0, 16'(63 * 256));
        seen_pos = 1'b0;
        seen_neg = 1'b0;
        waited = 0;
        while (!(seen_pos && seen_neg) && waited < 200) begin
            @(negedge clk);
            waited++;
            if (sample_l == tone_hi)
                seen_pos = 1'b1;
            else if (sample_l == -tone_hi)
                seen_neg = 1'b1;
            else
                check_sample("tone level", sample_l, tone_hi);
            check_sample("tone right channel", sample_r, sample_l);
        end
        if (!(seen_pos && seen_neg))
            timed_out("tone of both polarities");
        opl_set(OPL_REG_KEY_FNUM_HI, 8'h00);
        @(negedge clk);
        check_sample("key off left", sample_l, 16'sd0);
        check_sample("key off right", sample_r, 16'sd0);
        test_done("5 tone channel");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sound.f
common/sound_pkg.sv
common/reg_bus_if.sv
dsp/sound_dsp.sv
opl/opl_timers.sv
opl/opl_tone.sv
source/sound.sv
sim/sound_tb.sv

//--- source/sound.sv
/*
 * sound card top: io and fm port decode, timing registers,
 * DSP sample widening and half-scale mix of DSP and tone channel
 * sample_r mirrors sample_l, there is no panning
 */
`timescale 1ns/1ps
`default_nettype none

module sound
    import sound_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    output logic                irq,

    input  logic [3:0]          io_address,
    input  logic                io_read,
    input  logic                io_write,
    input  logic [7:0]          io_writedata,
    output logic [7:0]          io_readdata,

    input  logic [1:0]          fm_address,
    input  logic                fm_read,
    input  logic                fm_write,
    input  logic [7:0]          fm_writedata,
    output logic [7:0]          fm_readdata,

    output logic                dma_req,
    input  logic                dma_ack,
    input  logic                dma_terminal,
    input  logic [7:0]          dma_readdata,

    output logic [SAMPLE_W-1:0] sample_l,
    output logic [SAMPLE_W-1:0] sample_r,

    input  logic [8:0]          mgmt_address,
    input  logic                mgmt_write,
    input  logic [31:0]         mgmt_writedata
);

    reg_bus_if dsp_bus ();
    reg_bus_if opl_bus ();

    logic                io_is_opl;
    logic                fm_is_opl;
    logic                sel_io;
    logic                dsp_irq;
    logic                timer_irq;
    logic                sample_do;
    logic [7:0]          sample_value;
    logic                sample_disabled;
    logic [9:0]          fnum;
    logic                key_on;
    logic [5:0]          level;
    logic [SAMPLE_W-1:0] tone_sample;
    logic [SAMPLE_W-1:0] sample_dsp;
    logic [12:0]         period_80us;
    logic [9:0]          sample_cycles;
    logic [9:0]          sample_cnt;
    logic                sample_tick;

    // ------------------------------
    // decode, io 8/9 and fm 0/1 go to the OPL
    assign io_is_opl = io_address[3:1] == 3'b100;
    assign fm_is_opl = !fm_address[1];
    assign sel_io    = io_is_opl && (io_write || !fm_write);  // io write wins

    assign dsp_bus.addr      = io_address;
    assign dsp_bus.read      = io_read && !io_is_opl;
    assign dsp_bus.write     = io_write && !io_is_opl;
    assign dsp_bus.writedata = io_writedata;

    assign opl_bus.addr      = {3'b000, sel_io ? io_address[0] : fm_address[0]};
    assign opl_bus.read      = sel_io ? io_read : (fm_read && fm_is_opl);
    assign opl_bus.write     = (io_write && io_is_opl) || (fm_write && fm_is_opl);
    assign opl_bus.writedata = sel_io ? io_writedata : fm_writedata;

    assign io_readdata = io_is_opl ? opl_bus.readdata : dsp_bus.readdata;
    assign fm_readdata = fm_is_opl ? opl_bus.readdata : 8'hFF;

    assign irq = dsp_irq || timer_irq;

    // ------------------------------
    // timing registers and sample tick
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            period_80us   <= PERIOD_80US_RESET;
            sample_cycles <= SAMPLE_CYCLES_RESET;
            sample_cnt    <= 10'd0;
        end else begin
            if (mgmt_write && mgmt_address == MGMT_ADDR_80US)
                period_80us <= mgmt_writedata[12:0];
            if (mgmt_write && mgmt_address == MGMT_ADDR_SAMPLE)
                sample_cycles <= mgmt_writedata[9:0];
            sample_cnt <= sample_tick ? 10'd0 : sample_cnt + 10'd1;
        end
    end

    assign sample_tick = {1'b0, sample_cnt} + 11'd1 >= {1'b0, sample_cycles};

    sound_dsp u_dsp (
        .clk             (clk),
        .rst_n           (rst_n),
        .bus             (dsp_bus),
        .irq             (dsp_irq),
        .dma_req         (dma_req),
        .dma_ack         (dma_ack),
        .dma_terminal    (dma_terminal),
        .dma_readdata    (dma_readdata),
        .sample_do       (sample_do),
        .sample_value    (sample_value),
        .sample_disabled (sample_disabled),
        .mgmt_address    (mgmt_address),
        .mgmt_write      (mgmt_write),
        .mgmt_writedata  (mgmt_writedata)
    );

    opl_timers u_opl_timers (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (opl_bus),
        .period_80us (period_80us),
        .timer_irq   (timer_irq),
        .fnum        (fnum),
        .key_on      (key_on),
        .level       (level)
    );

    opl_tone u_opl_tone (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_tick (sample_tick),
        .fnum        (fnum),
        .key_on      (key_on),
        .level       (level),
        .tone_sample (tone_sample)
    );

    // ------------------------------
    // unsigned byte to signed 16 bit, then half-scale mix
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            sample_dsp <= '0;
        else if (sample_disabled)
            sample_dsp <= '0;                   // speaker off
        else if (sample_do)
            sample_dsp <= {~sample_value[7], sample_value[6:0], sample_value};
    end

    assign sample_l = {sample_dsp[SAMPLE_W-1], sample_dsp[SAMPLE_W-1:1]}
                    + {tone_sample[SAMPLE_W-1], tone_sample[SAMPLE_W-1:1]};
    assign sample_r = sample_l;

endmodule

`default_nettype wire
